// File: src/eth_lite_pkg.sv
package eth_lite_pkg;

  // One frame byte with framing flags
  typedef struct packed {
    logic [7:0] dat;
    logic       val;
    logic       sof;
    logic       eof;
  } byte_stream_t;

  typedef struct packed {
    logic [11:0] len; // Byte count of a stored frame
  } frame_desc_t;

  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ipv4_t;

  localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
  localparam logic [15:0] ETH_TYPE_ARP  = 16'h0806;
  localparam logic [7:0]  IP_PROTO_UDP  = 8'd17;

  // Byte offsets from start of Ethernet header
  localparam int OFS_ETHTYPE  = 12;
  localparam int OFS_IP_LEN   = 16;
  localparam int OFS_PROTO    = 23;
  localparam int OFS_SRC_IP   = 26;
  localparam int OFS_DST_IP   = 30;
  localparam int OFS_SRC_PORT = 34;
  localparam int OFS_DST_PORT = 36;
  localparam int OFS_UDP_CSUM = 40;

  localparam int ARP_LEN  = 42; // Full ARP reply, no padding
  localparam int ECHO_LAG = 36; // Echo delay line stages

endpackage

// File: src/frame_fifo.sv
`timescale 1ns/1ps

module frame_fifo #(
  parameter type entry_t = logic [7:0],
  parameter int  DEPTH   = 4
) (
  input  logic   clk,
  input  logic   rst,
  input  logic   push,
  input  entry_t din,
  input  logic   pop,
  output entry_t dout,
  output logic   empty
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  entry_t        mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   fill;

  // Wrap at DEPTH, which need not be a power of two
  function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
    return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= din;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop) rd_ptr <= next_ptr(rd_ptr);
      fill <= fill + (AW+1)'(push) - (AW+1)'(pop);
    end
  end

  assign dout  = mem[rd_ptr]; // Head entry, no read latency
  assign empty = (fill == '0);

endmodule

// File: src/arp_responder.sv
`timescale 1ns/1ps

module arp_responder #(
  parameter eth_lite_pkg::mac_addr_t MAC_ADDR   = 48'h02_00_5e_10_00_01,
  parameter int                      FIFO_DEPTH = 256
) (
  input  logic                       clk,
  input  logic                       rst,
  input  eth_lite_pkg::byte_stream_t rx,
  input  eth_lite_pkg::ipv4_t        local_ipv4,
  output eth_lite_pkg::byte_stream_t out,
  input  logic                       credit,
  output logic                       drop
);

  localparam int ALEN = eth_lite_pkg::ARP_LEN;
  localparam int CW   = $clog2(FIFO_DEPTH + 1);
  localparam int ET   = eth_lite_pkg::OFS_ETHTYPE;

  logic [11:0]             idx;
  logic [11:0]             cnt;
  eth_lite_pkg::mac_addr_t dst_mac;
  eth_lite_pkg::mac_addr_t sha;
  eth_lite_pkg::mac_addr_t rep_mac;
  logic [15:0]             eth_type;
  logic [15:0]             opcode;
  eth_lite_pkg::ipv4_t     spa;
  eth_lite_pkg::ipv4_t     tpa;
  eth_lite_pkg::ipv4_t     tpa_full;
  eth_lite_pkg::ipv4_t     rep_ip;
  logic                    is_req;
  logic                    can_send;
  logic                    busy;
  logic [5:0]              ocnt;
  logic [CW-1:0]           crd;
  logic [8*ALEN-1:0]       reply;

  assign idx = rx.sof ? '0 : cnt;

  always_ff @(posedge clk) begin
    if (rst) cnt <= '0;
    else if (rx.val) cnt <= idx + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (rx.val) begin
      if (idx < 6) dst_mac <= {dst_mac[39:0], rx.dat};
      if (idx == ET || idx == ET + 1) eth_type <= {eth_type[7:0], rx.dat};
      if (idx == 20 || idx == 21) opcode <= {opcode[7:0], rx.dat};
      if (idx >= 22 && idx < 28) sha <= {sha[39:0], rx.dat}; // Sender MAC
      if (idx >= 28 && idx < 32) spa <= {spa[23:0], rx.dat};
      if (idx >= 38 && idx < 42) tpa <= {tpa[23:0], rx.dat};
    end
  end

  // Last target IP byte may arrive with eof
  assign tpa_full = (idx == 41) ? {tpa[23:0], rx.dat} : tpa;

  assign is_req = rx.val && rx.eof && idx >= 41 &&
                  eth_type == eth_lite_pkg::ETH_TYPE_ARP && opcode == 16'd1 &&
                  tpa_full == local_ipv4 && (dst_mac == '1 || dst_mac == MAC_ADDR);
  assign can_send = !busy && crd >= CW'(ALEN);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      ocnt <= '0;
      drop <= 1'b0;
    end else begin
      drop <= is_req && !can_send;
      if (is_req && can_send) begin
        busy <= 1'b1;
        ocnt <= '0;
      end else if (busy) begin
        if (ocnt == 6'(ALEN - 1)) busy <= 1'b0;
        else ocnt <= ocnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (is_req && can_send) begin
      rep_mac <= sha;
      rep_ip  <= spa;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) crd <= CW'(FIFO_DEPTH);
    else crd <= crd + CW'(credit) - CW'(out.val);
  end

  assign reply = {rep_mac, MAC_ADDR, eth_lite_pkg::ETH_TYPE_ARP,
                  16'h0001, eth_lite_pkg::ETH_TYPE_IPV4, 8'd6, 8'd4, 16'h0002, // Opcode reply
                  MAC_ADDR, local_ipv4, rep_mac, rep_ip};

  always_comb begin
    out.dat = reply[8*(ALEN-1-int'(ocnt)) +: 8];
    out.val = busy;
    out.sof = busy && ocnt == '0;
    out.eof = busy && ocnt == 6'(ALEN - 1);
  end

endmodule

// File: src/udp_echo.sv
`timescale 1ns/1ps

module udp_echo #(
  parameter eth_lite_pkg::mac_addr_t MAC_ADDR   = 48'h02_00_5e_10_00_01,
  parameter int                      FIFO_DEPTH = 256,
  parameter int                      MAX_FRAME  = 128
) (
  input  logic                       clk,
  input  logic                       rst,
  input  eth_lite_pkg::byte_stream_t rx,
  input  eth_lite_pkg::ipv4_t        local_ipv4,
  output eth_lite_pkg::byte_stream_t out,
  input  logic                       credit,
  output logic                       drop
);

  localparam int LAG = eth_lite_pkg::ECHO_LAG;
  localparam int CW  = $clog2(FIFO_DEPTH + 1);
  localparam int ET  = eth_lite_pkg::OFS_ETHTYPE;
  localparam int IL  = eth_lite_pkg::OFS_IP_LEN;
  localparam int SI  = eth_lite_pkg::OFS_SRC_IP;
  localparam int DI  = eth_lite_pkg::OFS_DST_IP;
  localparam int SP  = eth_lite_pkg::OFS_SRC_PORT;
  localparam int DP  = eth_lite_pkg::OFS_DST_PORT;
  localparam int CS  = eth_lite_pkg::OFS_UDP_CSUM;

  eth_lite_pkg::byte_stream_t dly [LAG];
  eth_lite_pkg::byte_stream_t tail;
  logic [11:0]                idx;
  logic [11:0]                cnt;
  logic [11:0]                oidx;
  logic [11:0]                ocnt;
  eth_lite_pkg::mac_addr_t    dst_mac;
  eth_lite_pkg::mac_addr_t    src_mac;
  logic [15:0]                eth_type;
  logic [15:0]                ip_len;
  logic [15:0]                src_port;
  logic [15:0]                dst_port;
  logic [7:0]                 ver_ihl;
  logic [7:0]                 proto;
  eth_lite_pkg::ipv4_t        src_ip;
  eth_lite_pkg::ipv4_t        dst_ip;
  logic                       is_match;
  logic                       accept;
  logic                       pass;
  logic [CW-1:0]              crd;

  // Delay line advances every cycle, idle gap covers the flush
  always_ff @(posedge clk) begin
    if (rst) begin
      dly <= '{default: '0};
    end else begin
      dly[0] <= rx;
      for (int i = 1; i < LAG; i++) dly[i] <= dly[i-1];
    end
  end
  assign tail = dly[LAG-1];

  assign idx  = rx.sof ? '0 : cnt;
  assign oidx = tail.sof ? '0 : ocnt;

  always_ff @(posedge clk) begin
    if (rx.val) begin
      if (idx < 6) dst_mac <= {dst_mac[39:0], rx.dat};
      if (idx >= 6 && idx < 12) src_mac <= {src_mac[39:0], rx.dat};
      if (idx == ET || idx == ET + 1) eth_type <= {eth_type[7:0], rx.dat};
      if (idx == ET + 2) ver_ihl <= rx.dat;
      if (idx == IL || idx == IL + 1) ip_len <= {ip_len[7:0], rx.dat};
      if (idx == eth_lite_pkg::OFS_PROTO) proto <= rx.dat;
      if (idx >= SI && idx < DI) src_ip <= {src_ip[23:0], rx.dat};
      if (idx >= DI && idx < SP) dst_ip <= {dst_ip[23:0], rx.dat};
      if (idx == SP || idx == SP + 1) src_port <= {src_port[7:0], rx.dat};
      if (idx == DP || idx == DP + 1) dst_port <= {dst_port[7:0], rx.dat};
    end
  end

  // Decision on last destination IP byte
  assign is_match = rx.val && idx == 12'(DI + 3) && dst_mac == MAC_ADDR &&
                    eth_type == eth_lite_pkg::ETH_TYPE_IPV4 && ver_ihl == 8'h45 &&
                    proto == eth_lite_pkg::IP_PROTO_UDP && int'(ip_len) + 14 <= MAX_FRAME &&
                    {dst_ip[23:0], rx.dat} == local_ipv4;
  assign accept = is_match && crd >= CW'(MAX_FRAME);

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt  <= '0;
      ocnt <= '0;
      pass <= 1'b0;
      drop <= 1'b0;
      crd  <= CW'(FIFO_DEPTH);
    end else begin
      if (rx.val) cnt <= idx + 1'b1;
      if (tail.val) ocnt <= oidx + 1'b1;
      if (rx.val && rx.sof) pass <= 1'b0;
      else if (is_match) pass <= accept;
      else if (tail.val && tail.eof) pass <= 1'b0;
      drop <= is_match && !accept;
      crd  <= crd + CW'(credit) - CW'(out.val);
    end
  end

  always_comb begin
    int k;
    k = int'(oidx);
    out     = tail;
    out.val = tail.val && pass;
    out.sof = tail.sof && pass;
    out.eof = tail.eof && pass;
    if (k < 6) out.dat = src_mac[8*(5-k) +: 8];
    else if (k < 12) out.dat = MAC_ADDR[8*(11-k) +: 8];
    else if (k >= SI && k < DI) out.dat = dst_ip[8*(DI-1-k) +: 8];
    else if (k >= DI && k < SP) out.dat = src_ip[8*(SP-1-k) +: 8];
    else if (k >= SP && k < DP) out.dat = dst_port[8*(DP-1-k) +: 8];
    else if (k >= DP && k < DP + 2) out.dat = src_port[8*(DP+1-k) +: 8];
    else if (k == CS || k == CS + 1) out.dat = 8'h00; // UDP checksum off
  end

endmodule

// File: src/tx_arbiter.sv
`timescale 1ns/1ps

module tx_arbiter #(
  parameter int FIFO_DEPTH = 256
) (
  input  logic                       clk,
  input  logic                       rst,
  input  eth_lite_pkg::byte_stream_t arp_in,
  input  eth_lite_pkg::byte_stream_t echo_in,
  output logic                       arp_credit,
  output logic                       echo_credit,
  output eth_lite_pkg::byte_stream_t tx,
  input  logic                       tx_credit
);

  localparam int MW = 16;

  eth_lite_pkg::byte_stream_t src      [2];
  eth_lite_pkg::byte_stream_t head     [2];
  eth_lite_pkg::frame_desc_t  desc_in  [2];
  eth_lite_pkg::frame_desc_t  desc_out [2];
  logic [11:0]                len_cnt  [2];
  logic [1:0]                 byte_empty;
  logic [1:0]                 desc_empty;
  logic [1:0]                 pop_byte;
  logic [1:0]                 pop_desc;
  logic                       busy;
  logic                       cur;  // Source of frame in progress
  logic                       rr;   // Preferred source on a tie
  logic                       sel;
  logic                       start;
  logic                       send;
  logic [11:0]                rem;
  logic [MW-1:0]              mac_crd;

  assign src[0] = arp_in;
  assign src[1] = echo_in;

  for (genvar s = 0; s < 2; s++) begin : g_src
    always_ff @(posedge clk) begin
      if (rst) len_cnt[s] <= '0;
      else if (src[s].val) len_cnt[s] <= src[s].eof ? '0 : len_cnt[s] + 1'b1;
    end
    assign desc_in[s] = '{len: len_cnt[s] + 12'd1};

    frame_fifo #(.entry_t(eth_lite_pkg::byte_stream_t), .DEPTH(FIFO_DEPTH)) u_bytes (
      .clk(clk), .rst(rst), .push(src[s].val), .din(src[s]),
      .pop(pop_byte[s]), .dout(head[s]), .empty(byte_empty[s])
    );

    frame_fifo #(.entry_t(eth_lite_pkg::frame_desc_t), .DEPTH(4)) u_desc (
      .clk(clk), .rst(rst), .push(src[s].val && src[s].eof), .din(desc_in[s]),
      .pop(pop_desc[s]), .dout(desc_out[s]), .empty(desc_empty[s])
    );
  end

  assign sel   = (desc_empty == 2'b00) ? rr : desc_empty[0];
  assign start = !busy && desc_empty != 2'b11;
  assign send  = busy && mac_crd != '0 && !byte_empty[cur];

  assign pop_desc    = start ? (sel ? 2'b10 : 2'b01) : 2'b00;
  assign pop_byte    = send ? (cur ? 2'b10 : 2'b01) : 2'b00;
  assign arp_credit  = pop_byte[0];
  assign echo_credit = pop_byte[1];

  always_comb begin
    tx     = head[cur];
    tx.val = send;
    tx.sof = send && head[cur].sof;
    tx.eof = send && head[cur].eof;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy    <= 1'b0;
      cur     <= 1'b0;
      rr      <= 1'b0;
      rem     <= '0;
      mac_crd <= '0;
    end else begin
      mac_crd <= mac_crd + MW'(tx_credit) - MW'(send);
      if (start) begin
        busy <= 1'b1;
        cur  <= sel;
        rr   <= !sel;
        rem  <= desc_out[sel].len;
      end else if (send) begin
        rem <= rem - 1'b1;
        if (head[cur].eof || rem == 12'd1) busy <= 1'b0; // Frame done
      end
    end
  end

endmodule

// File: src/eth_lite_top.sv
`timescale 1ns/1ps

module eth_lite_top #(
  parameter eth_lite_pkg::mac_addr_t MAC_ADDR   = 48'h02_00_5e_10_00_01,
  parameter int                      FIFO_DEPTH = 256,
  parameter int                      MAX_FRAME  = 128 // Not above FIFO_DEPTH
) (
  input  logic                       clk,
  input  logic                       rst,
  input  eth_lite_pkg::byte_stream_t rx,
  input  eth_lite_pkg::ipv4_t        local_ipv4,
  output eth_lite_pkg::byte_stream_t tx,
  input  logic                       tx_credit,
  output logic                       rx_drop
);

  eth_lite_pkg::byte_stream_t arp_out;
  eth_lite_pkg::byte_stream_t echo_out;
  logic                       arp_credit;
  logic                       echo_credit;
  logic                       arp_drop;
  logic                       echo_drop;

  arp_responder #(.MAC_ADDR(MAC_ADDR), .FIFO_DEPTH(FIFO_DEPTH)) u_arp (
    .clk(clk), .rst(rst), .rx(rx), .local_ipv4(local_ipv4),
    .out(arp_out), .credit(arp_credit), .drop(arp_drop)
  );

  udp_echo #(.MAC_ADDR(MAC_ADDR), .FIFO_DEPTH(FIFO_DEPTH), .MAX_FRAME(MAX_FRAME)) u_echo (
    .clk(clk), .rst(rst), .rx(rx), .local_ipv4(local_ipv4),
    .out(echo_out), .credit(echo_credit), .drop(echo_drop)
  );

  tx_arbiter #(.FIFO_DEPTH(FIFO_DEPTH)) u_arb (
    .clk(clk), .rst(rst), .arp_in(arp_out), .echo_in(echo_out),
    .arp_credit(arp_credit), .echo_credit(echo_credit),
    .tx(tx), .tx_credit(tx_credit)
  );

  assign rx_drop = arp_drop | echo_drop;

endmodule

// File: test/eth_lite_properties.sv
`timescale 1ns/1ps

module eth_lite_properties (
  input logic                       clk,
  input logic                       rst,
  input eth_lite_pkg::byte_stream_t tx,
  input logic                       tx_credit,
  input logic                       rx_drop
);

  logic [15:0] credits; // MAC credit seen on the port
  logic        in_frame;

  always_ff @(posedge clk) begin
    if (rst) begin
      credits  <= '0;
      in_frame <= 1'b0;
    end else begin
      credits <= credits + 16'(tx_credit) - 16'(tx.val);
      if (tx.val && tx.eof) in_frame <= 1'b0;
      else if (tx.val && tx.sof) in_frame <= 1'b1;
    end
  end

  a_credit: assert property (@(posedge clk) disable iff (rst) tx.val |-> credits != '0)
    else $error("tx byte sent without MAC credit");

  a_one_sof: assert property (@(posedge clk) disable iff (rst) (tx.val && tx.sof) |-> !in_frame)
    else $error("second sof on tx before eof");

  a_reset_idle: assert property (@(posedge clk) rst |=> !tx.val && !rx_drop)
    else $error("tx or rx_drop active right after reset");

endmodule

bind eth_lite_top eth_lite_properties u_props (
  .clk(clk), .rst(rst), .tx(tx), .tx_credit(tx_credit), .rx_drop(rx_drop)
);

// File: test/tb_eth_lite.sv
`timescale 1ns/1ps

module tb_eth_lite;

  typedef logic [7:0] byte_q_t[$];

  localparam eth_lite_pkg::mac_addr_t MAC_ADDR  = 48'h02_00_5e_10_00_01;
  localparam eth_lite_pkg::mac_addr_t PEER_MAC  = 48'h0a_1b_2c_3d_4e_5f;
  localparam eth_lite_pkg::ipv4_t     LOCAL_IP  = 32'hc0a8_0a14;
  localparam eth_lite_pkg::ipv4_t     PEER_IP   = 32'hc0a8_0a01;
  localparam int                      FIFO_DEPTH = 256;
  localparam int                      MAX_FRAME  = 128;
  localparam int                      TIMEOUT    = 1000; // Idle cycles per wait

  logic                       clk = 1'b0;
  logic                       rst;
  eth_lite_pkg::byte_stream_t rx;
  eth_lite_pkg::ipv4_t        local_ipv4;
  eth_lite_pkg::byte_stream_t tx;
  logic                       tx_credit;
  logic                       rx_drop;

  integer  seed;
  int      errors;
  int      timeouts;
  int      drops;
  byte_q_t tx_bytes;

  eth_lite_top #(.MAC_ADDR(MAC_ADDR), .FIFO_DEPTH(FIFO_DEPTH), .MAX_FRAME(MAX_FRAME)) u_dut (
    .clk(clk), .rst(rst), .rx(rx), .local_ipv4(local_ipv4),
    .tx(tx), .tx_credit(tx_credit), .rx_drop(rx_drop)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    if (!rst && rx_drop) drops <= drops + 1;
  end

  function automatic byte_q_t to_bytes(input logic [8*42-1:0] v);
    byte_q_t q;
    for (int i = 0; i < 42; i++) q.push_back(v[8*(41-i) +: 8]);
    return q;
  endfunction

  // Broadcast request from the peer
  function automatic byte_q_t arp_request(input eth_lite_pkg::ipv4_t target_ip);
    return to_bytes({48'hffff_ffff_ffff, PEER_MAC, eth_lite_pkg::ETH_TYPE_ARP,
                     16'h0001, eth_lite_pkg::ETH_TYPE_IPV4, 8'd6, 8'd4, 16'h0001,
                     PEER_MAC, PEER_IP, 48'h0, target_ip});
  endfunction

  function automatic byte_q_t arp_answer();
    return to_bytes({PEER_MAC, MAC_ADDR, eth_lite_pkg::ETH_TYPE_ARP,
                     16'h0001, eth_lite_pkg::ETH_TYPE_IPV4, 8'd6, 8'd4, 16'h0002,
                     MAC_ADDR, LOCAL_IP, PEER_MAC, PEER_IP});
  endfunction

  function automatic byte_q_t udp_request(input eth_lite_pkg::mac_addr_t dst_mac,
                                          input logic [7:0] proto,
                                          input eth_lite_pkg::ipv4_t dst_ip,
                                          input int pay_len);
    byte_q_t     q;
    logic [15:0] ip_len;
    logic [15:0] udp_len;
    ip_len  = 16'(28 + pay_len);
    udp_len = 16'(8 + pay_len);
    q = to_bytes({dst_mac, PEER_MAC, eth_lite_pkg::ETH_TYPE_IPV4, 8'h45, 8'h00, ip_len,
                  16'h1c46, 16'h4000, 8'h40, proto, 16'hb1e6, PEER_IP, dst_ip,
                  16'hc350, 16'd7, udp_len, 16'h5a5a}); // Nonzero UDP checksum
    for (int i = 0; i < pay_len; i++) q.push_back(8'($random(seed)));
    return q;
  endfunction

  function automatic byte_q_t echo_answer(input byte_q_t req);
    byte_q_t q;
    q = req;
    for (int i = 0; i < 6; i++) begin
      q[i]     = req[6 + i];
      q[6 + i] = MAC_ADDR[8*(5-i) +: 8];
    end
    for (int i = 0; i < 4; i++) begin
      q[eth_lite_pkg::OFS_SRC_IP + i] = req[eth_lite_pkg::OFS_DST_IP + i];
      q[eth_lite_pkg::OFS_DST_IP + i] = req[eth_lite_pkg::OFS_SRC_IP + i];
    end
    for (int i = 0; i < 2; i++) begin
      q[eth_lite_pkg::OFS_SRC_PORT + i] = req[eth_lite_pkg::OFS_DST_PORT + i];
      q[eth_lite_pkg::OFS_DST_PORT + i] = req[eth_lite_pkg::OFS_SRC_PORT + i];
      q[eth_lite_pkg::OFS_UDP_CSUM + i] = 8'h00;
    end
    return q;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic compare_bytes(input string name, input byte_q_t expected,
                               input byte_q_t actual);
    check_value({name, " length"}, 32'(expected.size()), 32'(actual.size()));
    for (int i = 0; i < expected.size() && i < actual.size(); i++)
      check_value($sformatf("%s byte %0d", name, i), 32'(expected[i]), 32'(actual[i]));
  endtask

  task automatic reset_dut();
    @(negedge clk);
    rst <= 1'b1;
    rx  <= '0;
    repeat (10) @(negedge clk);
    rst <= 1'b0;
  endtask

  // Back-to-back bytes followed by the idle gap the engines need
  task automatic send_frame(input byte_q_t q);
    for (int i = 0; i < q.size(); i++) begin
      @(negedge clk);
      rx <= '{dat: q[i], val: 1'b1, sof: i == 0, eof: i == q.size() - 1};
    end
    @(negedge clk);
    rx <= '0;
    repeat (40) @(negedge clk);
  endtask

  // Grants credit every cycle or at random with random_credit
  task automatic collect_tx(input string name, input int n_frames, input bit random_credit);
    int frames;
    int idle;
    bit first;
    frames = 0;
    idle   = 0;
    first  = 1'b1;
    tx_bytes.delete();
    while (frames < n_frames && idle < TIMEOUT) begin
      @(negedge clk);
      tx_credit <= random_credit ? (($random(seed) & 3) == 0) : 1'b1;
      @(posedge clk);
      if (tx.val) begin
        check_value($sformatf("%s sof at byte %0d", name, tx_bytes.size()),
                    32'(first), 32'(tx.sof));
        tx_bytes.push_back(tx.dat);
        idle  = 0;
        first = tx.eof; // Next byte opens a frame
        if (tx.eof) frames++;
      end else begin
        idle++;
      end
    end
    @(negedge clk);
    tx_credit <= 1'b0;
    if (frames < n_frames) begin
      $display("%s: timed out waiting for tx frame %0d", name, frames + 1);
      timeouts++;
    end
  endtask

  task automatic expect_quiet(input string name, input int cycles);
    int seen;
    seen = 0;
    repeat (cycles) begin
      @(posedge clk);
      if (tx.val) seen++;
    end
    check_value({name, " tx bytes"}, 0, 32'(seen));
  endtask

  task automatic arp_request_answered();
    reset_dut();
    fork
      send_frame(arp_request(LOCAL_IP));
      collect_tx("arp reply", 1, 1'b0);
    join
    compare_bytes("arp reply", arp_answer(), tx_bytes);
    expect_quiet("arp single reply", 100);
  endtask

  task automatic udp_datagram_echoed();
    byte_q_t req;
    req = udp_request(MAC_ADDR, eth_lite_pkg::IP_PROTO_UDP, LOCAL_IP,
                      16 + int'($random(seed) & 31));
    reset_dut();
    fork
      send_frame(req);
      collect_tx("udp echo", 1, 1'b0);
    join
    compare_bytes("udp echo", echo_answer(req), tx_bytes);
  endtask

  task automatic foreign_frames_ignored();
    byte_q_t reqs[4];
    string   names[4];
    int      base;
    reqs[0]  = arp_request(32'hc0a8_0a63);
    reqs[1]  = udp_request(MAC_ADDR, eth_lite_pkg::IP_PROTO_UDP, 32'hc0a8_0a63, 20);
    reqs[2]  = udp_request(MAC_ADDR, 8'd6, LOCAL_IP, 20);
    reqs[3]  = udp_request(MAC_ADDR, eth_lite_pkg::IP_PROTO_UDP, LOCAL_IP, 100);
    names[0] = "arp other ip";
    names[1] = "udp other ip";
    names[2] = "non-udp ipv4";
    names[3] = "oversize udp";
    reset_dut();
    base = drops;
    tx_credit <= 1'b1; // Open credit so a stray reply would reach tx
    for (int i = 0; i < 4; i++) begin
      fork
        send_frame(reqs[i]);
        expect_quiet(names[i], reqs[i].size() + 150);
      join
    end
    @(negedge clk);
    tx_credit <= 1'b0;
    check_value("ignored frames drops", 32'(base), 32'(drops));
  endtask

  task automatic replies_not_interleaved();
    byte_q_t req;
    req = udp_request(MAC_ADDR, eth_lite_pkg::IP_PROTO_UDP, LOCAL_IP, 24);
    reset_dut();
    fork
      begin
        send_frame(req);
        send_frame(arp_request(LOCAL_IP));
      end
      collect_tx("echo then arp", 2, 1'b0);
    join
    compare_bytes("echo then arp", {echo_answer(req), arp_answer()}, tx_bytes);
  endtask

  task automatic stalled_tx_released();
    byte_q_t req;
    req = udp_request(MAC_ADDR, eth_lite_pkg::IP_PROTO_UDP, LOCAL_IP, 40);
    reset_dut();
    send_frame(req);
    send_frame(arp_request(LOCAL_IP));
    expect_quiet("no credit", 200);
    collect_tx("random credit", 2, 1'b1);
    compare_bytes("random credit", {echo_answer(req), arp_answer()}, tx_bytes);
  endtask

  task automatic full_engine_drops();
    byte_q_t req;
    byte_q_t expected;
    int      base;
    int      accepted;
    int      room;
    int      want;
    room = FIFO_DEPTH;
    want = 0;
    while (room >= MAX_FRAME) begin // Frames that fit the initial credit
      room -= 100;
      want++;
    end
    accepted = 0;
    reset_dut();
    base = drops;
    for (int i = 0; i < 6 && drops == base; i++) begin
      req = udp_request(MAC_ADDR, eth_lite_pkg::IP_PROTO_UDP, LOCAL_IP, 58);
      send_frame(req);
      if (drops == base) begin
        expected = {expected, echo_answer(req)};
        accepted++;
      end
    end
    check_value("full engine accepted", 32'(want), 32'(accepted));
    check_value("full engine drop pulses", 32'(base + 1), 32'(drops));
    collect_tx("full engine drain", accepted, 1'b0);
    compare_bytes("full engine drain", expected, tx_bytes);
  endtask

  initial begin
    seed       = 32'he0d4a686;
    rst        = 1'b1;
    rx         = '0;
    local_ipv4 = LOCAL_IP;
    tx_credit  = 1'b0;
    errors     = 0;
    timeouts   = 0;
    arp_request_answered();
    udp_datagram_echoed();
    foreign_frames_ignored();
    replies_not_interleaved();
    stalled_tx_released();
    full_engine_drops();
    $display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
src/eth_lite_pkg.sv
src/frame_fifo.sv
src/arp_responder.sv
src/udp_echo.sv
src/tx_arbiter.sv
src/eth_lite_top.sv
test/eth_lite_properties.sv
test/tb_eth_lite.sv

// File: Makefile
TOP = tb_eth_lite

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -Mdir obj_dir \
		--top-module $(TOP) -f vlog.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "Test passed"

clean:
	rm -rf obj_dir
